//--- hw/alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_consts.svh"

module alu (
	input  logic [`WORD_W-1:0]   y,
	input  logic [`WORD_W-1:0]   b,
	input  alu_pkg::alu_op_e     opcode,
	input  logic                 branch_taken,
	output logic [`RESULT_W-1:0] c
);
	import alu_pkg::*;

	logic [`WORD_W-1:0]   adder_sum;
	logic [`WORD_W-1:0]   sub_diff;
	logic [`WORD_W-1:0]   and_out;
	logic [`WORD_W-1:0]   or_out;
	logic [`WORD_W-1:0]   neg_out;
	logic [`WORD_W-1:0]   not_out;
	logic [`WORD_W-1:0]   shift_out;
	logic [`WORD_W-1:0]   quo_out;
	logic [`WORD_W-1:0]   rem_out;
	logic [`RESULT_W-1:0] mul_out;
	shift_op_e            shift_sel;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// simple ops
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign adder_sum = y + b;
	assign sub_diff  = y - b;
	assign and_out   = y & b;
	assign or_out    = y | b;
	assign neg_out   = ~b + 1'b1;
	assign not_out   = ~b;

	// shifter function from the opcode.
	always_comb begin
		case (opcode)
			op_shra: shift_sel = shift_shra;
			op_shl:  shift_sel = shift_shl;
			op_ror:  shift_sel = shift_ror;
			op_rol:  shift_sel = shift_rol;
			default: shift_sel = shift_shr;
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// sub-units
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	shift_rotate_unit u_shift (
		.value  (y),
		.amount (b[`SHAMT_W-1:0]),
		.sel    (shift_sel),
		.result (shift_out)
	);

	booth_multiplier u_mul (
		.multiplicand (y),
		.multiplier   (b),
		.product      (mul_out)
	);

	restoring_divider u_div (
		.dividend  (y),
		.divisor   (b),
		.quotient  (quo_out),
		.remainder (rem_out)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// result select
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		case (opcode)
			op_add, op_ld, op_ldi, op_st, op_addi: c = {{`WORD_W{1'b0}}, adder_sum};
			op_sub:                                c = {{`WORD_W{1'b0}}, sub_diff};
			op_and, op_andi:                       c = {{`WORD_W{1'b0}}, and_out};
			op_or, op_ori:                         c = {{`WORD_W{1'b0}}, or_out};
			op_neg:                                c = {{`WORD_W{1'b0}}, neg_out};
			op_not:                                c = {{`WORD_W{1'b0}}, not_out};
			op_shr, op_shra, op_shl, op_ror, op_rol: begin
				c = {{`WORD_W{1'b0}}, shift_out};
			end
			op_mul:                                c = mul_out;
			// remainder goes to hi, quotient to lo.
			op_div:                                c = {rem_out, quo_out};
			op_br: begin
				c = {{`WORD_W{1'b0}}, (branch_taken ? adder_sum : y)};
			end
			// jr, jal, in, out, mfhi, mflo are handled outside the ALU.
			default:                               c = '0;
		endcase
	end

	always_comb begin
		if (opcode != op_mul && opcode != op_div) begin
			assert (c[`RESULT_W-1:`WORD_W] == '0)
				else $error("alu: hi half set for opcode %s", opcode.name());
		end
	end

endmodule

`default_nettype wire

//--- hw/alu_pipe.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_consts.svh"

module alu_pipe (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               in_valid,
	input  alu_pkg::alu_op_e   opcode,
	input  logic [`WORD_W-1:0] operand_y,
	input  logic [`WORD_W-1:0] operand_b,
	input  logic               branch_taken,
	output logic               out_valid,
	output logic [`WORD_W-1:0] z_hi,
	output logic [`WORD_W-1:0] z_lo
);
	import alu_pkg::*;

	logic [`WORD_W-1:0]   y_reg;
	logic [`WORD_W-1:0]   b_reg;
	alu_op_e              op_reg;
	logic                 flag_reg;
	logic                 v1;
	logic [`RESULT_W-1:0] c;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stage 1, operand registers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			y_reg    <= '0;
			b_reg    <= '0;
			op_reg   <= op_ld;
			flag_reg <= 1'b0;
			v1       <= 1'b0;
		end else begin
			v1 <= in_valid;
			// operands only move on a strobe.
			if (in_valid) begin
				y_reg    <= operand_y;
				b_reg    <= operand_b;
				op_reg   <= opcode;
				flag_reg <= branch_taken;
			end
		end
	end

	alu u_alu (
		.y            (y_reg),
		.b            (b_reg),
		.opcode       (op_reg),
		.branch_taken (flag_reg),
		.c            (c)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stage 2, Z register
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			z_hi      <= '0;
			z_lo      <= '0;
		end else begin
			out_valid <= v1;
			// Z holds its last result between valid outputs.
			if (v1) begin
				z_hi <= c[`RESULT_W-1:`WORD_W];
				z_lo <= c[`WORD_W-1:0];
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	a_out_valid_known: assert property (
		@(posedge clk) disable iff (!rst_n)
		!$isunknown(out_valid)
	) else $error("alu_pipe: out_valid unknown");

	// two-cycle latency, once reset has been released long enough.
	a_two_cycle_latency: assert property (
		@(posedge clk) disable iff (!rst_n)
		($past(rst_n) && $past(rst_n, 2)) |-> (out_valid == $past(in_valid, 2))
	) else $error("alu_pipe: out_valid does not follow in_valid by two cycles");

endmodule

`default_nettype wire

//--- hw/alu_pkg.sv
`default_nettype none

package alu_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// instruction opcodes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [4:0] {
		op_ld   = 5'd0,
		op_ldi  = 5'd1,
		op_st   = 5'd2,
		op_add  = 5'd3,
		op_sub  = 5'd4,
		op_shr  = 5'd5,
		op_shra = 5'd6,
		op_shl  = 5'd7,
		op_ror  = 5'd8,
		op_rol  = 5'd9,
		op_and  = 5'd10,
		op_or   = 5'd11,
		op_addi = 5'd12,
		op_andi = 5'd13,
		op_ori  = 5'd14,
		op_mul  = 5'd15,
		op_div  = 5'd16,
		op_neg  = 5'd17,
		op_not  = 5'd18,
		op_br   = 5'd19,
		op_jr   = 5'd20,
		op_jal  = 5'd21,
		op_in   = 5'd22,
		op_out  = 5'd23,
		op_mfhi = 5'd24,
		op_mflo = 5'd25
	} alu_op_e;

	// shifter function select.
	typedef enum logic [2:0] {
		shift_shr  = 3'd0,
		shift_shra = 3'd1,
		shift_shl  = 3'd2,
		shift_ror  = 3'd3,
		shift_rol  = 3'd4
	} shift_op_e;

endpackage

`default_nettype wire

//--- hw/booth_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_consts.svh"

module booth_multiplier (
	input  logic [`WORD_W-1:0]   multiplicand,
	input  logic [`WORD_W-1:0]   multiplier,
	output logic [`RESULT_W-1:0] product
);

	localparam int DIGITS = `WORD_W / 2;

	logic [`WORD_W:0]     mplr_ext;
	logic [`RESULT_W-1:0] mcand_ext;
	logic [`RESULT_W-1:0] mcand_x2;
	logic [`RESULT_W-1:0] pp [DIGITS];

	// implicit zero below the lsb starts the recoding.
	assign mplr_ext = {multiplier, 1'b0};

	assign mcand_ext = {{(`RESULT_W - `WORD_W){multiplicand[`WORD_W-1]}}, multiplicand};
	assign mcand_x2  = {mcand_ext[`RESULT_W-2:0], 1'b0};

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// radix-4 recoding
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	for (genvar d = 0; d < DIGITS; d++) begin : g_digit
		logic [2:0] triplet;

		assign triplet = mplr_ext[2*d +: 3];

		// each digit is one of -2, -1, 0, +1, +2.
		always_comb begin
			case (triplet)
				3'b001, 3'b010: pp[d] = mcand_ext << (2 * d);
				3'b011:         pp[d] = mcand_x2 << (2 * d);
				3'b100:         pp[d] = (-mcand_x2) << (2 * d);
				3'b101, 3'b110: pp[d] = (-mcand_ext) << (2 * d);
				default:        pp[d] = '0;
			endcase
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// partial product sum
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		logic [`RESULT_W-1:0] acc;

		acc = '0;
		for (int i = 0; i < DIGITS; i++) begin
			acc = acc + pp[i];
		end
		product = acc;
	end

endmodule

`default_nettype wire

//--- hw/restoring_divider.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_consts.svh"

module restoring_divider (
	input  logic [`WORD_W-1:0] dividend,
	input  logic [`WORD_W-1:0] divisor,
	output logic [`WORD_W-1:0] quotient,
	output logic [`WORD_W-1:0] remainder
);

	logic               dvd_neg;
	logic               dvs_neg;
	logic [`WORD_W-1:0] dvd_mag;
	logic [`WORD_W-1:0] dvs_mag;
	logic [`WORD_W-1:0] quo_mag;
	logic [`WORD_W-1:0] rem_mag;

	assign dvd_neg = dividend[`WORD_W-1];
	assign dvs_neg = divisor[`WORD_W-1];

	// the most negative value maps to 2^31, which still fits unsigned.
	assign dvd_mag = dvd_neg ? -dividend : dividend;
	assign dvs_mag = dvs_neg ? -divisor : divisor;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// unrolled restoring steps
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		logic [`WORD_W:0]   part_rem;
		logic [`WORD_W+1:0] trial;

		part_rem = '0;
		trial    = '0;
		quo_mag  = '0;
		for (int i = `WORD_W - 1; i >= 0; i--) begin
			part_rem = {part_rem[`WORD_W-1:0], dvd_mag[i]};
			trial    = {1'b0, part_rem} - {2'b00, dvs_mag};
			// keep the difference only when it did not go negative.
			if (!trial[`WORD_W+1]) begin
				part_rem   = trial[`WORD_W:0];
				quo_mag[i] = 1'b1;
			end
		end
		rem_mag = part_rem[`WORD_W-1:0];
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// sign fix-up
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		if (divisor == '0) begin
			quotient  = '1;
			remainder = dividend;
		end else begin
			quotient  = (dvd_neg ^ dvs_neg) ? -quo_mag : quo_mag;
			remainder = dvd_neg ? -rem_mag : rem_mag;
		end
	end

	// remainder after sign fix-up must stay below the divisor in size.
	always_comb begin
		logic [`WORD_W-1:0] rem_out_mag;

		rem_out_mag = remainder[`WORD_W-1] ? -remainder : remainder;
		if (divisor != '0) begin
			assert (rem_out_mag < dvs_mag)
				else $error("divider: |rem| %0d not below |divisor| %0d", rem_out_mag, dvs_mag);
		end
	end

endmodule

`default_nettype wire

//--- hw/shift_rotate_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_consts.svh"

module shift_rotate_unit (
	input  logic [`WORD_W-1:0]  value,
	input  logic [`SHAMT_W-1:0] amount,
	input  alu_pkg::shift_op_e  sel,
	output logic [`WORD_W-1:0]  result
);
	import alu_pkg::*;

	logic [2*`WORD_W-1:0] doubled;
	logic [`SHAMT_W-1:0]  rol_amount;
	logic [`WORD_W-1:0]   shr_out;
	logic [`WORD_W-1:0]   shra_out;
	logic [`WORD_W-1:0]   shl_out;
	logic [`WORD_W-1:0]   ror_out;
	logic [`WORD_W-1:0]   rol_out;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// shifts
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign shr_out  = value >> amount;
	assign shra_out = $signed(value) >>> amount;
	assign shl_out  = value << amount;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// rotates
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// a window over two copies gives the rotated word.
	assign doubled = {value, value};

	// left by n is right by (32 - n) mod 32.
	assign rol_amount = ~amount + 1'b1;

	assign ror_out = doubled[amount +: `WORD_W];
	assign rol_out = doubled[rol_amount +: `WORD_W];

	always_comb begin
		case (sel)
			shift_shr:  result = shr_out;
			shift_shra: result = shra_out;
			shift_shl:  result = shl_out;
			shift_ror:  result = ror_out;
			shift_rol:  result = rol_out;
			default:    result = value;
		endcase
	end

endmodule

`default_nettype wire

//--- include/alu_consts.svh
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// datapath widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// operand and register width.
`define WORD_W 32

// shift and rotate amount, taken from the low bits of b.
`define SHAMT_W 5

// Z register, hi and lo halves together.
`define RESULT_W 64

`endif

//--- run_sim.sh
#!/bin/sh
# builds the alu_pipe testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module alu_pipe_tb -Mdir obj_dir -f src.f \
	|| { echo "build failed"; exit 1; }

./obj_dir/Valu_pipe_tb | tee /dev/stderr \
	| grep -q "Test completed successfully" && exit 0 || exit 1

//--- src.f
+incdir+include
hw/alu_pkg.sv
hw/shift_rotate_unit.sv
hw/booth_multiplier.sv
hw/restoring_divider.sv
hw/alu.sv
hw/alu_pipe.sv
tests/alu_pipe_tb.sv

//--- tests/alu_pipe_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_consts.svh"

module alu_pipe_tb;
	import alu_pkg::*;

	localparam int DRAIN_TIMEOUT = 50;

	logic                 clk = 1'b0;
	logic                 rst_n;
	logic                 in_valid;
	alu_op_e              opcode;
	logic [`WORD_W-1:0]   operand_y;
	logic [`WORD_W-1:0]   operand_b;
	logic                 branch_taken;
	logic                 out_valid;
	logic [`WORD_W-1:0]   z_hi;
	logic [`WORD_W-1:0]   z_lo;

	logic [31:0]          lcg_state;
	logic [`RESULT_W-1:0] exp_q [$];
	alu_op_e              op_q [$];
	int                   edge_q [$];
	logic [`RESULT_W-1:0] last_z;
	logic [`WORD_W-1:0]   corners [6];
	int                   cycle_count;
	int                   error_count;
	int                   missing_count;

	alu_pipe UUT (
		.clk          (clk),
		.rst_n        (rst_n),
		.in_valid     (in_valid),
		.opcode       (opcode),
		.operand_y    (operand_y),
		.operand_b    (operand_b),
		.branch_taken (branch_taken),
		.out_valid    (out_valid),
		.z_hi         (z_hi),
		.z_lo         (z_lo)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// expected Z for one operation, straight from the instruction set rules.
	function automatic logic [`RESULT_W-1:0] alu_ref(input alu_op_e op,
			input logic [`WORD_W-1:0] y, input logic [`WORD_W-1:0] b, input logic taken);
		logic signed [`RESULT_W-1:0] ys;
		logic signed [`RESULT_W-1:0] bs;
		logic signed [`RESULT_W-1:0] q;
		logic signed [`RESULT_W-1:0] r;
		logic [`WORD_W-1:0]          word;
		int                          n;

		ys = $signed(y);
		bs = $signed(b);
		n = int'(b[`SHAMT_W-1:0]);
		case (op)
			op_add, op_ld, op_ldi, op_st, op_addi: word = y + b;
			op_sub:          word = y - b;
			op_and, op_andi: word = y & b;
			op_or, op_ori:   word = y | b;
			op_neg:          word = -b;
			op_not:          word = ~b;
			op_shr:          word = y >> n;
			op_shra:         word = $signed(y) >>> n;
			op_shl:          word = y << n;
			op_ror:          word = (y >> n) | (y << (32 - n));
			op_rol:          word = (y << n) | (y >> (32 - n));
			op_br:           word = taken ? y + b : y;
			op_mul:          return ys * bs;
			op_div: begin
				if (b == '0) begin
					return {y, {`WORD_W{1'b1}}};
				end
				// 64-bit math keeps the most negative value over -1 in range.
				q = ys / bs;
				r = ys % bs;
				return {r[`WORD_W-1:0], q[`WORD_W-1:0]};
			end
			default:         word = '0;
		endcase
		return {{`WORD_W{1'b0}}, word};
	endfunction

	task automatic check_value(input logic [`RESULT_W-1:0] expected,
			input logic [`RESULT_W-1:0] actual, input string what);
		if (expected !== actual) begin
			$display("Fail at %0t ns: %s, expected %h, got %h", $time, what, expected, actual);
			error_count++;
		end
	endtask

	task automatic issue(input alu_op_e op, input logic [`WORD_W-1:0] y,
			input logic [`WORD_W-1:0] b, input logic taken);
		in_valid     = 1'b1;
		opcode       = op;
		operand_y    = y;
		operand_b    = b;
		branch_taken = taken;
		exp_q.push_back(alu_ref(op, y, b, taken));
		op_q.push_back(op);
		// sampled by the coming edge.
		edge_q.push_back(cycle_count + 1);
		@(posedge clk);
		#1;
		in_valid = 1'b0;
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			#1;
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// scoreboard
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always @(negedge clk) begin
		logic [`RESULT_W-1:0] expected;
		alu_op_e              exp_op;
		int                   exp_edge;

		if (!rst_n) begin
			check_value('0, {63'b0, out_valid}, "out_valid in reset");
			check_value('0, {z_hi, z_lo}, "Z in reset");
			last_z = '0;
		end else if (out_valid) begin
			if (exp_q.size() == 0) begin
				$display("unexpected result at %0t ns with no operation pending", $time);
				error_count++;
			end else begin
				expected = exp_q.pop_front();
				exp_op   = op_q.pop_front();
				exp_edge = edge_q.pop_front();
				check_value(expected, {z_hi, z_lo}, $sformatf("opcode %s", exp_op.name()));
				// seen at the next edge, two after the strobe's edge.
				check_value(64'(exp_edge), 64'(cycle_count - 1),
					$sformatf("latency of opcode %s", exp_op.name()));
			end
			last_z = {z_hi, z_lo};
		end else begin
			check_value(last_z, {z_hi, z_lo}, "Z held while idle");
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin
		logic [31:0] rnd;
		int          waited;

		rst_n         = 1'b0;
		in_valid      = 1'b0;
		opcode        = op_ld;
		operand_y     = '0;
		operand_b     = '0;
		branch_taken  = 1'b0;
		lcg_state     = 32'h7ef3ff23;
		cycle_count   = 0;
		error_count   = 0;
		missing_count = 0;
		last_z        = '0;
		corners       = '{32'h0, 32'h1, 32'hffffffff, 32'h80000000, 32'h7fffffff, 32'h7};

		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
		idle(2);

		// every opcode with random operands, back to back.
		for (int i = 0; i < 26; i++) begin
			for (int k = 0; k < 4; k++) begin
				issue(alu_op_e'(i), next_rand(), next_rand(), next_rand() > 32'h8000_0000);
			end
		end

		// shifts and rotates, with junk above the amount bits.
		for (int i = int'(op_shr); i <= int'(op_rol); i++) begin
			foreach (corners[a]) begin
				rnd = next_rand();
				issue(alu_op_e'(i), next_rand() | 32'h8000_0000,
					{rnd[31:`SHAMT_W], corners[a][`SHAMT_W-1:0]}, 1'b0);
			end
			issue(alu_op_e'(i), 32'h8000_0001, 32'hffff_ffe0, 1'b0);
		end

		// multiply and divide over the corner values.
		foreach (corners[a]) begin
			foreach (corners[d]) begin
				issue(op_mul, corners[a], corners[d], 1'b0);
				issue(op_div, corners[a], corners[d], 1'b0);
			end
			issue(op_div, next_rand(), corners[a], 1'b0);
			issue(op_mul, next_rand(), corners[a], 1'b0);
		end

		for (int k = 0; k < 4; k++) begin
			rnd = next_rand();
			issue(op_br, rnd, next_rand(), 1'b1);
			issue(op_br, rnd, next_rand(), 1'b0);
		end

		// random traffic with idle gaps of zero to three cycles.
		for (int k = 0; k < 60; k++) begin
			rnd = next_rand();
			issue(alu_op_e'(5'(rnd % 32'd26)), next_rand(), next_rand(), rnd[7]);
			idle(int'(rnd[31:30]));
		end

		waited = 0;
		while (exp_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
			@(posedge clk);
			waited++;
		end
		if (exp_q.size() != 0) begin
			$display("timeout: %0d results never appeared at the output", exp_q.size());
			missing_count = exp_q.size();
		end
		idle(4);

		$display("errors: %0d mismatches, %0d missing results", error_count, missing_count);
		if (error_count == 0 && missing_count == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
